//--- hdl/display_pkg.sv
// ----------------------------------------------------------
// shared pixel, address and bus types for the display frame
// store. modules refer to them by scoped names.
// ----------------------------------------------------------
`default_nettype none

package display_pkg;

  localparam int PIXEL_BITS = 4;        // one nibble per pixel.
  localparam int PIXELS_PER_WORD = 8;   // 8 nibbles fill a 32-bit word.
  localparam int PIXEL_ADDR_BITS = 18;  // covers 640 x 400 pixels.

  typedef logic [PIXEL_BITS-1:0] pixel_t;
  typedef logic [PIXEL_ADDR_BITS-1:0] pixel_addr_t;  // raster-order pixel index.
  typedef logic [PIXEL_BITS*PIXELS_PER_WORD-1:0] ram_word_t;

  // pixel writer strobe into the back buffer
  typedef struct packed {
    logic        enable;
    pixel_addr_t address;
    pixel_t      data;
  } pixel_write_t;

  typedef struct packed {
    logic        write_enable;
    pixel_addr_t address;     // shared by the write and the read.
    pixel_t      write_data;
  } ram_port_t;

  typedef struct packed {
    logic   valid;
    logic   line_start;       // first active pixel of a line.
    logic   frame_start;      // first active pixel of a frame.
    pixel_t data;
  } pixel_stream_t;

  typedef enum logic {
    BUFFER_A,
    BUFFER_B
  } buffer_sel_t;

endpackage

`default_nettype wire

//--- hdl/pixel_ram.sv
// ----------------------------------------------------------
// one frame buffer of packed 8-pixel words. nibble writes keep
// the rest of the word, reads return a registered nibble.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixel_ram #(
  parameter int WORDS = 32000
) (
  input  logic                   clock_in,
  input  logic                   reset_n_in,
  input  display_pkg::ram_port_t port,
  output display_pkg::pixel_t    read_data
);

  localparam int LANE_BITS = $clog2(display_pkg::PIXELS_PER_WORD);
  localparam int INDEX_BITS = (WORDS > 1) ? $clog2(WORDS) : 1;

  display_pkg::ram_word_t mem [WORDS];

  logic [INDEX_BITS-1:0] word_index;
  logic [LANE_BITS-1:0]  lane;

  assign word_index = port.address[LANE_BITS +: INDEX_BITS];  // upper bits pick the word.
  assign lane = port.address[LANE_BITS-1:0];                  // low bits pick the nibble.

  // read-modify-write of a single nibble
  always_ff @(posedge clock_in) begin
    if (port.write_enable) begin
      mem[word_index][lane*display_pkg::PIXEL_BITS +: display_pkg::PIXEL_BITS] <=
        port.write_data;
    end
  end

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      read_data <= '0;
    end else begin
      read_data <=
        mem[word_index][lane*display_pkg::PIXEL_BITS +: display_pkg::PIXEL_BITS];  // old data on a collision.
    end
  end

endmodule

`default_nettype wire

//--- hdl/frame_buffers.sv
// ----------------------------------------------------------
// two frame buffers with swap at the frame boundary. the back
// buffer takes pixel writes or the clear, the front is read.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_buffers #(
  parameter int PIXEL_COUNT = 256000
) (
  input  logic                      clock_in,
  input  logic                      reset_n_in,
  input  display_pkg::pixel_write_t pixel_write,
  input  display_pkg::pixel_addr_t  read_address,
  input  logic                      switch_request,
  output display_pkg::pixel_t       read_data,
  output logic                      clear_busy
);

  localparam int WORDS = PIXEL_COUNT / display_pkg::PIXELS_PER_WORD;
  localparam display_pkg::pixel_addr_t LAST_CLEAR =
    display_pkg::pixel_addr_t'(PIXEL_COUNT - 1);

  display_pkg::buffer_sel_t displayed;
  display_pkg::buffer_sel_t other_buffer;
  display_pkg::buffer_sel_t front_sel;
  display_pkg::buffer_sel_t read_sel_d1;
  display_pkg::buffer_sel_t read_sel_d2;

  logic [1:0] switch_sync;
  logic       switch_edge;
  logic       swap_pending;
  logic       swap_now;
  logic       clearing;

  display_pkg::pixel_addr_t clear_address;
  display_pkg::ram_port_t   read_port;
  display_pkg::ram_port_t   back_port;
  display_pkg::ram_port_t   port_a;
  display_pkg::ram_port_t   port_b;
  display_pkg::pixel_t      read_data_a;
  display_pkg::pixel_t      read_data_b;

  pixel_ram #(.WORDS(WORDS)) u_buffer_a (
    .clock_in   (clock_in),
    .reset_n_in (reset_n_in),
    .port       (port_a),
    .read_data  (read_data_a)
  );

  pixel_ram #(.WORDS(WORDS)) u_buffer_b (
    .clock_in   (clock_in),
    .reset_n_in (reset_n_in),
    .port       (port_b),
    .read_data  (read_data_b)
  );

  assign switch_edge = switch_sync[0] & ~switch_sync[1];  // rising edge only.
  // a swap waits for a finished clear, so a half-cleared buffer is never shown
  assign swap_now = swap_pending && (read_address == '0) && !clearing;
  assign other_buffer = (displayed == display_pkg::BUFFER_A) ? display_pkg::BUFFER_B
                                                             : display_pkg::BUFFER_A;
  assign front_sel = swap_now ? other_buffer : displayed;  // routes the swap cycle too.
  assign clear_busy = clearing | swap_now;

  assign read_port = '{write_enable: 1'b0, address: read_address, write_data: '0};

  always_comb begin
    if (clear_busy) begin
      back_port = '{write_enable: 1'b1, address: clear_address, write_data: '0};
    end else begin
      back_port = '{write_enable: pixel_write.enable,
                    address:      pixel_write.address,
                    write_data:   pixel_write.data};
    end
  end

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      displayed     <= display_pkg::BUFFER_A;
      switch_sync   <= 2'b00;
      swap_pending  <= 1'b0;
      clearing      <= 1'b1;  // buffer B is cleared after reset.
      clear_address <= '0;
    end else begin
      switch_sync <= {switch_sync[0], switch_request};
      displayed   <= front_sel;
      if (swap_now) begin
        swap_pending <= 1'b0;  // a request on this cycle merges.
      end else if (switch_edge) begin
        swap_pending <= 1'b1;
      end
      if (clear_busy) begin
        if (clear_address == LAST_CLEAR) begin
          clearing      <= 1'b0;
          clear_address <= '0;
        end else begin
          clearing      <= 1'b1;
          clear_address <= clear_address + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      port_a      <= '0;
      port_b      <= '0;
      read_sel_d1 <= display_pkg::BUFFER_A;
      read_sel_d2 <= display_pkg::BUFFER_A;
    end else begin
      if (front_sel == display_pkg::BUFFER_A) begin
        port_a <= read_port;
        port_b <= back_port;
      end else begin
        port_a <= back_port;
        port_b <= read_port;
      end
      read_sel_d1 <= front_sel;    // follows the address down the read path.
      read_sel_d2 <= read_sel_d1;
    end
  end

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      read_data <= '0;
    end else begin
      read_data <= (read_sel_d2 == display_pkg::BUFFER_A) ? read_data_a : read_data_b;
    end
  end

endmodule

`default_nettype wire

//--- hdl/raster_scanner.sv
// ----------------------------------------------------------
// raster timing for the front buffer. makes the read address
// and the valid, line and frame markers aligned to read data.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module raster_scanner #(
  parameter int H_ACTIVE = 640,
  parameter int V_ACTIVE = 400,
  parameter int H_TOTAL  = 800,
  parameter int V_TOTAL  = 450
) (
  input  logic                     clock_in,
  input  logic                     reset_n_in,
  output display_pkg::pixel_addr_t read_address,
  output logic                     valid,
  output logic                     line_start,
  output logic                     frame_start
);

  localparam int H_BITS = $clog2(H_TOTAL);
  localparam int V_BITS = $clog2(V_TOTAL);
  localparam logic [H_BITS-1:0] H_LAST = H_BITS'(H_TOTAL - 1);
  localparam logic [V_BITS-1:0] V_LAST = V_BITS'(V_TOTAL - 1);
  localparam display_pkg::pixel_addr_t LAST_PIXEL =
    display_pkg::pixel_addr_t'(H_ACTIVE * V_ACTIVE - 1);

  logic [H_BITS-1:0] h_count;
  logic [V_BITS-1:0] v_count;
  logic              active;
  logic [2:0]        valid_pipe;  // 3 stages match the buffer read path.
  logic [2:0]        line_pipe;
  logic [2:0]        frame_pipe;

  assign active = (h_count < H_BITS'(H_ACTIVE)) && (v_count < V_BITS'(V_ACTIVE));

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      h_count      <= '0;
      v_count      <= '0;
      read_address <= '0;
      valid_pipe   <= '0;
      line_pipe    <= '0;
      frame_pipe   <= '0;
    end else begin
      if (h_count == H_LAST) begin
        h_count <= '0;
        v_count <= (v_count == V_LAST) ? '0 : v_count + 1'b1;
      end else begin
        h_count <= h_count + 1'b1;
      end
      // the address holds the next line start across horizontal blanking,
      // so it reads zero only between the last and first pixel of a frame
      if (active) begin
        read_address <= (read_address == LAST_PIXEL) ? '0 : read_address + 1'b1;
      end
      valid_pipe <= {valid_pipe[1:0], active};
      line_pipe  <= {line_pipe[1:0], active && (h_count == '0)};
      frame_pipe <= {frame_pipe[1:0], active && (h_count == '0) && (v_count == '0)};
    end
  end

  assign valid       = valid_pipe[2];
  assign line_start  = line_pipe[2];
  assign frame_start = frame_pipe[2];

endmodule

`default_nettype wire

//--- hdl/display_subsystem.sv
// ----------------------------------------------------------
// top of the double-buffered frame store. takes pixel writes
// and swap requests, sends the raster pixel stream.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module display_subsystem #(
  parameter int H_ACTIVE = 640,
  parameter int V_ACTIVE = 400,
  parameter int H_TOTAL  = 800,
  parameter int V_TOTAL  = 450
) (
  input  logic                       clock_in,
  input  logic                       reset_n_in,
  input  display_pkg::pixel_write_t  pixel_write,
  input  logic                       switch_request,
  output display_pkg::pixel_stream_t pixel_out,
  output logic                       clear_busy
);

  localparam int PIXEL_COUNT = H_ACTIVE * V_ACTIVE;  // sets RAM depth and clear length.

  display_pkg::pixel_addr_t read_address;
  display_pkg::pixel_t      read_data;
  logic                     valid;
  logic                     line_start;
  logic                     frame_start;

  raster_scanner #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL)
  ) u_raster_scanner (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .read_address (read_address),
    .valid        (valid),
    .line_start   (line_start),
    .frame_start  (frame_start)
  );

  frame_buffers #(.PIXEL_COUNT(PIXEL_COUNT)) u_frame_buffers (
    .clock_in       (clock_in),
    .reset_n_in     (reset_n_in),
    .pixel_write    (pixel_write),
    .read_address   (read_address),
    .switch_request (switch_request),
    .read_data      (read_data),
    .clear_busy     (clear_busy)
  );

  // markers arrive already delayed to line up with the data.
  assign pixel_out = '{valid:       valid,
                       line_start:  line_start,
                       frame_start: frame_start,
                       data:        read_data};

endmodule

`default_nettype wire

//--- tests/tb_display_subsystem.sv
// ----------------------------------------------------------
// testbench for the frame store. random writes and swaps from
// an LFSR are checked frame by frame against a two-buffer model.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_display_subsystem;

  localparam int H_ACTIVE = 16;
  localparam int V_ACTIVE = 4;
  localparam int H_TOTAL = 20;
  localparam int V_TOTAL = 6;
  localparam int PIXEL_COUNT = H_ACTIVE * V_ACTIVE;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int TEST_FRAMES = 10;
  localparam int CLOCK_NS = 8;
  localparam int RESET_CYCLES = 16;
  localparam int WATCHDOG_NS = (12 * FRAME_CYCLES + RESET_CYCLES + PIXEL_COUNT) * CLOCK_NS;

  logic                       clock_in;
  logic                       reset_n_in;
  logic                       switch_request;
  logic                       clear_busy;
  display_pkg::pixel_write_t  pixel_write;
  display_pkg::pixel_stream_t pixel_out;

  logic [15:0]         lfsr_state = 16'd48;
  display_pkg::pixel_t model_buf [2][PIXEL_COUNT];  // index 0 is buffer A.
  display_pkg::pixel_t expected_q [$];              // snapshot of the frame on screen.
  int                  front;
  bit                  front_known;  // buffer A holds no defined data until the first swap.
  bit                  swap_asked;
  int                  value_errors;
  int                  protocol_errors;

  display_subsystem #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL)
  ) u_display_subsystem (
    .clock_in       (clock_in),
    .reset_n_in     (reset_n_in),
    .pixel_write    (pixel_write),
    .switch_request (switch_request),
    .pixel_out      (pixel_out),
    .clear_busy     (clear_busy)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};  // taps 16 14 13 11.
  endfunction

  // one LFSR step per bit taken
  function automatic int random_bits(input int count);
    int value;
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
  endfunction

  task automatic note_value_error(input string msg);
    value_errors++;
    $display("CHECK FAILED at time %0t: %s", $time, msg);
  endtask

  task automatic note_protocol_error(input string msg);
    protocol_errors++;
    $display("protocol error at time %0t: %s", $time, msg);
  endtask

  initial begin
    clock_in = 1'b0;
    forever #(CLOCK_NS / 2) clock_in = ~clock_in;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    display_pkg::pixel_stream_t seen;
    display_pkg::pixel_t        expected;
    display_pkg::pixel_t        data_value;
    logic busy;
    int   i;
    int   addr;
    int   frames_seen;
    int   phase;
    int   pixel_index;
    int   line_count;
    int   clear_cycles;
    int   pulse_at;
    bit   clear_done;
    bit   allow_writes;
    bit   ask_swap;
    bit   double_pulse;
    reset_n_in = 1'b0;
    switch_request = 1'b0;
    pixel_write = '0;
    for (i = 0; i < PIXEL_COUNT; i++) begin
      model_buf[0][i] = '0;
      model_buf[1][i] = '0;
    end
    front = 0;
    front_known = 1'b0;
    swap_asked = 1'b0;
    frames_seen = 0;
    phase = 0;
    pixel_index = 0;
    line_count = 0;
    clear_cycles = 0;
    clear_done = 1'b0;
    allow_writes = 1'b0;
    ask_swap = 1'b0;
    double_pulse = 1'b0;
    pulse_at = 0;
    repeat (RESET_CYCLES) @(posedge clock_in);
    #1 reset_n_in = 1'b1;
    while (frames_seen <= TEST_FRAMES) begin
      seen = pixel_out;
      busy = clear_busy;
      // every clear, after reset and after each swap, lasts one frame of pixels
      if (busy) begin
        clear_cycles++;
      end else if (clear_cycles != 0) begin
        if (clear_cycles != PIXEL_COUNT) begin
          note_value_error($sformatf("clear_busy was high for %0d cycles, expected %0d",
                                     clear_cycles, PIXEL_COUNT));
        end
        clear_done = 1'b1;
        clear_cycles = 0;
      end
      if (seen.frame_start) begin
        if (frames_seen > 0 && (expected_q.size() != 0 || line_count != V_ACTIVE)) begin
          note_protocol_error($sformatf("frame %0d closed with %0d pixels missing, %0d lines",
                                        frames_seen, expected_q.size(), line_count));
        end
        if (swap_asked) begin
          front = 1 - front;
          for (i = 0; i < PIXEL_COUNT; i++) begin
            model_buf[1 - front][i] = '0;  // the old front is cleared.
          end
          front_known = 1'b1;
          swap_asked = 1'b0;
        end
        expected_q.delete();
        for (i = 0; i < PIXEL_COUNT; i++) begin
          expected_q.push_back(model_buf[front][i]);
        end
        frames_seen++;
        phase = 0;
        pixel_index = 0;
        line_count = 0;
        // frame 5 swaps back with no writes, so frame 6 must be blank
        allow_writes = (frames_seen > 1) && (frames_seen != 5);
        ask_swap = (frames_seen inside {1, 4, 5}) || (random_bits(1) == 1);
        double_pulse = (random_bits(1) == 1);
        pulse_at = 8 + random_bits(5);
      end
      if (seen.valid) begin
        if (frames_seen == 0) begin
          note_protocol_error("valid pixel before the first frame_start");
        end else if (expected_q.size() == 0) begin
          note_protocol_error("more valid pixels than one frame holds");
        end else begin
          expected = expected_q.pop_front();
          if (front_known && seen.data !== expected) begin
            note_value_error($sformatf("frame %0d pixel %0d is %h, expected %h",
                                       frames_seen, pixel_index, seen.data, expected));
          end
          if (seen.line_start != (pixel_index % H_ACTIVE == 0)) begin
            note_protocol_error($sformatf("line_start out of place at pixel %0d", pixel_index));
          end
          if (seen.frame_start != (pixel_index == 0)) begin
            note_protocol_error($sformatf("frame_start out of place at pixel %0d", pixel_index));
          end
          pixel_index++;
        end
        if (seen.line_start) begin
          line_count++;
        end
      end else if (seen.line_start || seen.frame_start) begin
        note_protocol_error("marker asserted without a valid pixel");
      end
      pixel_write = '0;
      if (frames_seen > 0) begin
        if (allow_writes && random_bits(2) == 0) begin
          addr = random_bits(6);
          data_value = display_pkg::pixel_t'(random_bits(4));
          pixel_write = '{enable: 1'b1,
                          address: display_pkg::pixel_addr_t'(addr),
                          data: data_value};
          if (!busy) begin
            model_buf[1 - front][addr] = data_value;  // dropped while clearing.
          end
        end
        switch_request = ask_swap && ((phase >= pulse_at && phase < pulse_at + 3) ||
                                      (double_pulse && phase >= 50 && phase < 53));
        if (ask_swap && phase == pulse_at) begin
          swap_asked = 1'b1;
        end
        phase++;
      end
      @(posedge clock_in);
      #1;
    end
    if (!clear_done) begin
      note_protocol_error("clear_busy never completed a clear after reset");
    end
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hdl/display_pkg.sv
hdl/pixel_ram.sv
hdl/frame_buffers.sv
hdl/raster_scanner.sv
hdl/display_subsystem.sv
tests/tb_display_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# builds the frame store testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_display_subsystem \
  -f filelist.f \
  -o tb_display_subsystem

./obj_dir/tb_display_subsystem > sim.log
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi
